// File: hw/kv_settings.svh
`ifndef KV_SETTINGS_SVH
`define KV_SETTINGS_SVH

// Key and value widths
`define KV_KEY_W 8
`define KV_VALUE_W 32

// Storage organisation
// Keys from KV_NUM_BANKS * KV_BANK_DEPTH up are out of range
`define KV_NUM_BANKS 2
`define KV_BANK_DEPTH 16

// Open transactions tracked per context FIFO
`define KV_CTXT_DEPTH 8

`endif

// File: hw/kv_pkg.sv
`default_nettype none

`include "kv_settings.svh"

package kv_pkg;

    typedef enum logic {
        OP_QUERY  = 1'b0,
        OP_UPDATE = 1'b1
    } kv_op_e;

    typedef enum logic {
        MODE_PRIO   = 1'b0,
        MODE_STATIC = 1'b1
    } kv_mode_e;

    // Valid and value are only meaningful for updates
    typedef struct packed {
        kv_op_e                 op;
        logic [`KV_KEY_W-1:0]   key;
        logic                   valid;
        logic [`KV_VALUE_W-1:0] value;
    } kv_req_t;

    typedef struct packed {
        logic                   error;
        logic                   valid;
        logic [`KV_VALUE_W-1:0] value;
    } kv_resp_t;

endpackage

`default_nettype wire

// File: hw/kv_mux_cfg.sv
`timescale 1ns/1ns
`default_nettype none

module kv_mux_cfg (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_cfg_wr,
    input  wire kv_pkg::kv_mode_e i_cfg_mode,
    input  wire logic             i_cfg_sel,
    output kv_pkg::kv_mode_e      o_mode,
    output logic                  o_static_sel
);

    kv_pkg::kv_mode_e mode_q;
    logic             sel_q;

    // Policy defaults to strict priority with requester 0 named
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            mode_q <= kv_pkg::MODE_PRIO;
            sel_q  <= 1'b0;
        end else if (i_cfg_wr) begin
            mode_q <= i_cfg_mode;
            sel_q  <= i_cfg_sel;
        end
    end

    assign o_mode       = mode_q;
    assign o_static_sel = sel_q;

endmodule

`default_nettype wire

// File: hw/kv_ctxt_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "kv_settings.svh"

module kv_ctxt_fifo #(
    parameter int WIDTH = 1
) (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_push,
    input  wire logic [WIDTH-1:0] i_tag,
    input  wire logic             i_pop,
    output logic      [WIDTH-1:0] o_tag,
    output logic                  o_full
);

    localparam int AW = $clog2(`KV_CTXT_DEPTH);

    logic [WIDTH-1:0] mem [`KV_CTXT_DEPTH];
    // One extra pointer bit tells full from empty
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr[AW-1:0]] <= i_tag;
        end
    end

    // Head of queue is the owner of the oldest open transaction
    assign o_tag  = mem[rd_ptr[AW-1:0]];
    assign o_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

`default_nettype wire

// File: hw/kv_req_mux.sv
`timescale 1ns/1ns
`default_nettype none

module kv_req_mux (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire kv_pkg::kv_mode_e i_mode,
    input  wire logic             i_static_sel,
    input  wire logic             i_hi_req,
    input  wire kv_pkg::kv_req_t  i_hi_cmd,
    input  wire logic             i_lo_req,
    input  wire kv_pkg::kv_req_t  i_lo_cmd,
    input  wire logic             i_rdy,
    input  wire logic             i_ack,
    input  wire kv_pkg::kv_resp_t i_resp,
    output logic                  o_hi_rdy,
    output logic                  o_hi_ack,
    output kv_pkg::kv_resp_t      o_hi_resp,
    output logic                  o_lo_rdy,
    output logic                  o_lo_ack,
    output kv_pkg::kv_resp_t      o_lo_resp,
    output logic                  o_req,
    output kv_pkg::kv_req_t       o_cmd
);

    // Select 0 is the high-priority requester, 1 the low-priority one
    logic sel;
    logic fifo_full;
    logic ret_sel;
    logic accept;

    always_comb begin
        if (i_mode == kv_pkg::MODE_PRIO) begin
            sel      = !i_hi_req;
            o_hi_rdy = i_rdy && !fifo_full;
            o_lo_rdy = i_rdy && !fifo_full && !i_hi_req;
        end else begin
            sel      = i_static_sel;
            o_hi_rdy = i_rdy && !fifo_full && !i_static_sel;
            o_lo_rdy = i_rdy && !fifo_full && i_static_sel;
        end
    end

    // Hold the request back while no context slot is free
    assign o_req  = (sel ? i_lo_req : i_hi_req) && !fifo_full;
    assign o_cmd  = sel ? i_lo_cmd : i_hi_cmd;
    assign accept = o_req && i_rdy;

    kv_ctxt_fifo #(
        .WIDTH ( 1 )
    ) u_ctxt_fifo (
        .clk     ( clk ),
        .i_rst_n ( i_rst_n ),
        .i_push  ( accept ),
        .i_tag   ( sel ),
        .i_pop   ( i_ack ),
        .o_tag   ( ret_sel ),
        .o_full  ( fifo_full )
    );

    // Route the response to the owner of the oldest transaction
    assign o_hi_ack  = i_ack && !ret_sel;
    assign o_lo_ack  = i_ack && ret_sel;
    assign o_hi_resp = ret_sel ? '0 : i_resp;
    assign o_lo_resp = ret_sel ? i_resp : '0;

endmodule

`default_nettype wire

// File: hw/kv_bank_demux.sv
`timescale 1ns/1ns
`default_nettype none

`include "kv_settings.svh"

module kv_bank_demux (
    input  wire logic                      clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_req,
    input  wire kv_pkg::kv_req_t           i_cmd,
    input  wire logic [`KV_NUM_BANKS-1:0]  i_bank_rdy,
    input  wire logic [`KV_NUM_BANKS-1:0]  i_bank_ack,
    input  wire kv_pkg::kv_resp_t          i_bank_resp [`KV_NUM_BANKS],
    output logic                           o_rdy,
    output logic                           o_ack,
    output kv_pkg::kv_resp_t               o_resp,
    output logic      [`KV_NUM_BANKS-1:0]  o_bank_req,
    output kv_pkg::kv_req_t                o_bank_cmd
);

    localparam int BANK_W = $clog2(`KV_NUM_BANKS);

    logic [BANK_W-1:0] bank_sel;
    logic [BANK_W-1:0] ret_bank;
    logic              fifo_full;
    logic              accept;

    // Lowest key bits pick the bank so one key always lands in one place
    assign bank_sel = i_cmd.key[BANK_W-1:0];

    always_comb begin
        for (int b = 0; b < `KV_NUM_BANKS; b++) begin
            o_bank_req[b] = i_req && !fifo_full && (bank_sel == b);
        end
    end

    assign o_bank_cmd = i_cmd;
    assign o_rdy      = i_bank_rdy[bank_sel] && !fifo_full;
    assign accept     = i_req && o_rdy;

    kv_ctxt_fifo #(
        .WIDTH ( BANK_W )
    ) u_ctxt_fifo (
        .clk     ( clk ),
        .i_rst_n ( i_rst_n ),
        .i_push  ( accept ),
        .i_tag   ( bank_sel ),
        .i_pop   ( o_ack ),
        .o_tag   ( ret_bank ),
        .o_full  ( fifo_full )
    );

    // Banks answer in accept order, so the oldest tag names the responder
    assign o_ack  = i_bank_ack[ret_bank];
    assign o_resp = i_bank_resp[ret_bank];

endmodule

`default_nettype wire

// File: hw/kv_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "kv_settings.svh"

module kv_bank (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_req,
    input  wire kv_pkg::kv_req_t  i_cmd,
    output logic                  o_rdy,
    output logic                  o_ack,
    output kv_pkg::kv_resp_t      o_resp
);

    localparam int BANK_W   = $clog2(`KV_NUM_BANKS);
    localparam int IDX_W    = $clog2(`KV_BANK_DEPTH);
    localparam int NUM_KEYS = `KV_NUM_BANKS * `KV_BANK_DEPTH;

    logic                   rdy_q;
    logic                   s1_req_q;
    kv_pkg::kv_req_t        s1_cmd_q;
    logic [IDX_W-1:0]       s1_idx;
    logic                   s1_in_range;
    logic                   s1_wr;
    logic                   ack_q;
    kv_pkg::kv_resp_t       resp_q;
    logic                   mem_valid [`KV_BANK_DEPTH];
    logic [`KV_VALUE_W-1:0] mem_value [`KV_BANK_DEPTH];

    // Ready comes up one cycle after reset and then stays up
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rdy_q    <= 1'b0;
            s1_req_q <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            rdy_q    <= 1'b1;
            s1_req_q <= i_req && rdy_q;
            ack_q    <= s1_req_q;
        end
    end

    // Stage 1 captures the accepted request
    always_ff @(posedge clk) begin
        if (i_req && rdy_q) begin
            s1_cmd_q <= i_cmd;
        end
    end

    // Entry index skips the bank bits of the key
    assign s1_idx      = s1_cmd_q.key[BANK_W +: IDX_W];
    assign s1_in_range = s1_cmd_q.key < NUM_KEYS;
    assign s1_wr       = s1_req_q && s1_in_range && (s1_cmd_q.op == kv_pkg::OP_UPDATE);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `KV_BANK_DEPTH; i++) begin
                mem_valid[i] <= 1'b0;
            end
        end else if (s1_wr) begin
            mem_valid[s1_idx] <= s1_cmd_q.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_wr) begin
            mem_value[s1_idx] <= s1_cmd_q.value;
        end
    end

    // Stage 2 forms the answer; updates report only the error flag
    always_ff @(posedge clk) begin
        if (s1_req_q) begin
            resp_q <= '0;
            if (!s1_in_range) begin
                resp_q.error <= 1'b1;
            end else if (s1_cmd_q.op == kv_pkg::OP_QUERY) begin
                resp_q.valid <= mem_valid[s1_idx];
                resp_q.value <= mem_value[s1_idx];
            end
        end
    end

    assign o_rdy  = rdy_q;
    assign o_ack  = ack_q;
    assign o_resp = resp_q;

endmodule

`default_nettype wire

// File: hw/kv_fabric_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "kv_settings.svh"

module kv_fabric_top (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_cfg_wr,
    input  wire kv_pkg::kv_mode_e i_cfg_mode,
    input  wire logic             i_cfg_sel,
    input  wire logic             i_hi_req,
    input  wire kv_pkg::kv_req_t  i_hi_cmd,
    output logic                  o_hi_rdy,
    output logic                  o_hi_ack,
    output kv_pkg::kv_resp_t      o_hi_resp,
    input  wire logic             i_lo_req,
    input  wire kv_pkg::kv_req_t  i_lo_cmd,
    output logic                  o_lo_rdy,
    output logic                  o_lo_ack,
    output kv_pkg::kv_resp_t      o_lo_resp
);

    kv_pkg::kv_mode_e       mode;
    logic                   static_sel;
    logic                   mrg_req;
    logic                   mrg_rdy;
    logic                   mrg_ack;
    kv_pkg::kv_req_t        mrg_cmd;
    kv_pkg::kv_resp_t       mrg_resp;
    logic [`KV_NUM_BANKS-1:0] bank_req;
    logic [`KV_NUM_BANKS-1:0] bank_rdy;
    logic [`KV_NUM_BANKS-1:0] bank_ack;
    kv_pkg::kv_req_t        bank_cmd;
    kv_pkg::kv_resp_t       bank_resp [`KV_NUM_BANKS];

    kv_mux_cfg u_mux_cfg (
        .clk          ( clk ),
        .i_rst_n      ( i_rst_n ),
        .i_cfg_wr     ( i_cfg_wr ),
        .i_cfg_mode   ( i_cfg_mode ),
        .i_cfg_sel    ( i_cfg_sel ),
        .o_mode       ( mode ),
        .o_static_sel ( static_sel )
    );

    kv_req_mux u_req_mux (
        .clk          ( clk ),
        .i_rst_n      ( i_rst_n ),
        .i_mode       ( mode ),
        .i_static_sel ( static_sel ),
        .i_hi_req     ( i_hi_req ),
        .i_hi_cmd     ( i_hi_cmd ),
        .i_lo_req     ( i_lo_req ),
        .i_lo_cmd     ( i_lo_cmd ),
        .i_rdy        ( mrg_rdy ),
        .i_ack        ( mrg_ack ),
        .i_resp       ( mrg_resp ),
        .o_hi_rdy     ( o_hi_rdy ),
        .o_hi_ack     ( o_hi_ack ),
        .o_hi_resp    ( o_hi_resp ),
        .o_lo_rdy     ( o_lo_rdy ),
        .o_lo_ack     ( o_lo_ack ),
        .o_lo_resp    ( o_lo_resp ),
        .o_req        ( mrg_req ),
        .o_cmd        ( mrg_cmd )
    );

    kv_bank_demux u_bank_demux (
        .clk         ( clk ),
        .i_rst_n     ( i_rst_n ),
        .i_req       ( mrg_req ),
        .i_cmd       ( mrg_cmd ),
        .i_bank_rdy  ( bank_rdy ),
        .i_bank_ack  ( bank_ack ),
        .i_bank_resp ( bank_resp ),
        .o_rdy       ( mrg_rdy ),
        .o_ack       ( mrg_ack ),
        .o_resp      ( mrg_resp ),
        .o_bank_req  ( bank_req ),
        .o_bank_cmd  ( bank_cmd )
    );

    for (genvar b = 0; b < `KV_NUM_BANKS; b++) begin : g_bank
        kv_bank u_bank (
            .clk     ( clk ),
            .i_rst_n ( i_rst_n ),
            .i_req   ( bank_req[b] ),
            .i_cmd   ( bank_cmd ),
            .o_rdy   ( bank_rdy[b] ),
            .o_ack   ( bank_ack[b] ),
            .o_resp  ( bank_resp[b] )
        );
    end

endmodule

`default_nettype wire

// File: testbench/kv_fabric_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "kv_settings.svh"

module kv_fabric_tb;

    localparam int CLK_PERIOD = 4;
    localparam int TIMEOUT    = 20;
    localparam int NUM_KEYS   = `KV_NUM_BANKS * `KV_BANK_DEPTH;
    localparam int NUM_REF    = 2 ** `KV_KEY_W;

    // Step kinds of the stimulus table
    localparam logic [1:0] K_REQ   = 2'd0;
    localparam logic [1:0] K_CFG   = 2'd1;
    localparam logic [1:0] K_BLOCK = 2'd2;
    localparam logic [1:0] K_PAIR  = 2'd3;
    localparam logic       HI      = 1'b0;
    localparam logic       LO      = 1'b1;

    typedef struct packed {
        logic [1:0]             kind;
        logic                   port;
        kv_pkg::kv_op_e         op;
        logic [`KV_KEY_W-1:0]   key;
        logic                   valid;
        logic [`KV_VALUE_W-1:0] value;
        kv_pkg::kv_mode_e       cfg_mode;
        logic                   cfg_sel;
        logic                   exp_error;
        logic                   exp_valid;
        logic [`KV_VALUE_W-1:0] exp_value;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic             cfg_wr;
    kv_pkg::kv_mode_e cfg_mode;
    logic             cfg_sel;
    logic             hi_req;
    logic             lo_req;
    kv_pkg::kv_req_t  hi_cmd;
    kv_pkg::kv_req_t  lo_cmd;
    logic             hi_rdy;
    logic             lo_rdy;
    logic             hi_ack;
    logic             lo_ack;
    kv_pkg::kv_resp_t hi_resp;
    kv_pkg::kv_resp_t lo_resp;
    logic [1:0]       rdy;
    logic [1:0]       ack;

    row_t                   rows [$];
    logic                   ref_valid [NUM_REF];
    logic [`KV_VALUE_W-1:0] ref_value [NUM_REF];
    int                     seed;
    int                     errors;

    kv_fabric_top dut (
        .clk        ( clk ),
        .i_rst_n    ( rst_n ),
        .i_cfg_wr   ( cfg_wr ),
        .i_cfg_mode ( cfg_mode ),
        .i_cfg_sel  ( cfg_sel ),
        .i_hi_req   ( hi_req ),
        .i_hi_cmd   ( hi_cmd ),
        .o_hi_rdy   ( hi_rdy ),
        .o_hi_ack   ( hi_ack ),
        .o_hi_resp  ( hi_resp ),
        .i_lo_req   ( lo_req ),
        .i_lo_cmd   ( lo_cmd ),
        .o_lo_rdy   ( lo_rdy ),
        .o_lo_ack   ( lo_ack ),
        .o_lo_resp  ( lo_resp )
    );

    assign rdy = {lo_rdy, hi_rdy};
    assign ack = {lo_ack, hi_ack};

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference model applied in table order, which is also accept order
    task automatic add_req(input logic [1:0] kind, input logic port, input kv_pkg::kv_op_e op,
                           input logic [`KV_KEY_W-1:0] key, input logic valid);
        row_t r;
        r = '0;
        r.kind      = kind;
        r.port      = port;
        r.op        = op;
        r.key       = key;
        r.valid     = valid;
        r.value     = $random(seed);
        r.exp_error = (key >= NUM_KEYS);
        if (kind != K_BLOCK && !r.exp_error) begin
            if (op == kv_pkg::OP_UPDATE) begin
                ref_valid[key] = valid;
                ref_value[key] = r.value;
            end else begin
                r.exp_valid = ref_valid[key];
                r.exp_value = ref_value[key];
            end
        end
        rows.push_back(r);
    endtask

    task automatic add_cfg(input kv_pkg::kv_mode_e mode, input logic sel);
        row_t r;
        r = '0;
        r.kind     = K_CFG;
        r.cfg_mode = mode;
        r.cfg_sel  = sel;
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int k = 0; k < NUM_REF; k++) begin
            ref_valid[k] = 1'b0;
            ref_value[k] = '0;
        end
        // Stored entries in both banks through both ports
        add_req(K_REQ, HI, kv_pkg::OP_UPDATE, 8'd4, 1'b1);
        add_req(K_REQ, LO, kv_pkg::OP_UPDATE, 8'd7, 1'b1);
        add_req(K_REQ, HI, kv_pkg::OP_UPDATE, 8'd18, 1'b1);
        add_req(K_REQ, LO, kv_pkg::OP_QUERY, 8'd4, 1'b0);
        add_req(K_REQ, HI, kv_pkg::OP_QUERY, 8'd7, 1'b0);
        add_req(K_REQ, LO, kv_pkg::OP_QUERY, 8'd18, 1'b0);
        add_req(K_REQ, HI, kv_pkg::OP_QUERY, 8'd9, 1'b0);
        // Key 40 shares its low bits with key 8
        add_req(K_REQ, LO, kv_pkg::OP_UPDATE, 8'd8, 1'b1);
        add_req(K_REQ, HI, kv_pkg::OP_UPDATE, 8'd40, 1'b1);
        add_req(K_REQ, LO, kv_pkg::OP_QUERY, 8'd40, 1'b0);
        add_req(K_REQ, HI, kv_pkg::OP_QUERY, 8'd8, 1'b0);
        add_req(K_REQ, HI, kv_pkg::OP_QUERY, 8'd255, 1'b0);
        // Clearing an entry
        add_req(K_REQ, LO, kv_pkg::OP_UPDATE, 8'd7, 1'b0);
        add_req(K_REQ, HI, kv_pkg::OP_QUERY, 8'd7, 1'b0);
        // Both requesters in the same cycle, one key per bank
        add_req(K_PAIR, HI, kv_pkg::OP_UPDATE, 8'd12, 1'b1);
        add_req(K_PAIR, LO, kv_pkg::OP_QUERY, 8'd7, 1'b0);
        add_req(K_PAIR, HI, kv_pkg::OP_QUERY, 8'd12, 1'b0);
        add_req(K_PAIR, LO, kv_pkg::OP_UPDATE, 8'd13, 1'b1);
        add_req(K_PAIR, HI, kv_pkg::OP_QUERY, 8'd13, 1'b0);
        add_req(K_PAIR, LO, kv_pkg::OP_QUERY, 8'd18, 1'b0);
        // Static select of the low-priority requester, then back to priority
        add_cfg(kv_pkg::MODE_STATIC, 1'b1);
        add_req(K_BLOCK, HI, kv_pkg::OP_QUERY, 8'd4, 1'b0);
        add_req(K_REQ, LO, kv_pkg::OP_QUERY, 8'd4, 1'b0);
        add_req(K_REQ, LO, kv_pkg::OP_UPDATE, 8'd21, 1'b1);
        add_cfg(kv_pkg::MODE_PRIO, 1'b0);
        add_req(K_REQ, HI, kv_pkg::OP_QUERY, 8'd21, 1'b0);
    endtask

    function automatic kv_pkg::kv_req_t to_cmd(input row_t r);
        kv_pkg::kv_req_t c;
        c.op    = r.op;
        c.key   = r.key;
        c.valid = r.valid;
        c.value = r.value;
        return c;
    endfunction

    task automatic drive(input logic port, input logic en, input kv_pkg::kv_req_t c);
        if (port == HI) begin
            hi_req <= en;
            hi_cmd <= c;
        end else begin
            lo_req <= en;
            lo_cmd <= c;
        end
    endtask

    task automatic write_cfg(input kv_pkg::kv_mode_e mode, input logic sel);
        @(posedge clk);
        cfg_wr   <= 1'b1;
        cfg_mode <= mode;
        cfg_sel  <= sel;
        @(posedge clk);
        cfg_wr   <= 1'b0;
    endtask

    // One transaction on one port; ok stays low when a wait runs out
    task automatic issue(input row_t r, output kv_pkg::kv_resp_t got, output time t_acc,
                         output logic ok);
        kv_pkg::kv_req_t c;
        int              n;
        c     = to_cmd(r);
        ok    = 1'b0;
        got   = '0;
        t_acc = 0;
        @(posedge clk);
        drive(r.port, 1'b1, c);
        n = 0;
        @(negedge clk);
        while (!rdy[r.port] && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rdy[r.port]) begin
            $display("Port %0d saw no rdy within %0d cycles", r.port, TIMEOUT);
            errors++;
            @(posedge clk);
            drive(r.port, 1'b0, c);
            return;
        end
        @(posedge clk);
        t_acc = $time;
        drive(r.port, 1'b0, c);
        n = 1;
        @(negedge clk);
        while (!ack[r.port] && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ack[r.port]) begin
            $display("Port %0d saw no ack within %0d cycles of its accept", r.port, TIMEOUT);
            errors++;
            return;
        end
        assert (n == 2) else begin
            $display("FAILED ack latency port %0d: got 0x%0h expected 0x2", r.port, n);
            errors++;
        end
        got = r.port ? lo_resp : hi_resp;
        ok  = 1'b1;
    endtask

    task automatic expect_stall(input row_t r);
        kv_pkg::kv_req_t c;
        c = to_cmd(r);
        @(posedge clk);
        drive(r.port, 1'b1, c);
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            assert (!rdy[r.port]) else begin
                $display("FAILED rdy port %0d: got 0x1 expected 0x0", r.port);
                errors++;
            end
        end
        @(posedge clk);
        drive(r.port, 1'b0, c);
    endtask

    task automatic check_resp(input row_t r, input kv_pkg::kv_resp_t got);
        assert (got.error == r.exp_error) else begin
            $display("FAILED resp.error key 0x%02h: got 0x%0h expected 0x%0h",
                     r.key, got.error, r.exp_error);
            errors++;
        end
        assert (got.valid == r.exp_valid) else begin
            $display("FAILED resp.valid key 0x%02h: got 0x%0h expected 0x%0h",
                     r.key, got.valid, r.exp_valid);
            errors++;
        end
        // Value of an invalid entry is unspecified
        if (r.exp_valid || r.op == kv_pkg::OP_UPDATE) begin
            assert (got.value == r.exp_value) else begin
                $display("FAILED resp.value key 0x%02h: got 0x%08h expected 0x%08h",
                         r.key, got.value, r.exp_value);
                errors++;
            end
        end
    endtask

    initial begin
        row_t             r;
        kv_pkg::kv_resp_t got_a;
        kv_pkg::kv_resp_t got_b;
        time              t_a;
        time              t_b;
        logic             ok_a;
        logic             ok_b;
        int               i;
        int               err_before;
        int               num_steps;
        int               failed_steps;
        seed         = 60175;
        errors       = 0;
        num_steps    = 0;
        failed_steps = 0;
        rst_n        = 1'b0;
        cfg_wr       = 1'b0;
        cfg_mode     = kv_pkg::MODE_PRIO;
        cfg_sel      = 1'b0;
        hi_req       = 1'b0;
        lo_req       = 1'b0;
        hi_cmd       = '0;
        lo_cmd       = '0;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        i = 0;
        while (i < rows.size()) begin
            r          = rows[i];
            err_before = errors;
            case (r.kind)
                K_CFG: write_cfg(r.cfg_mode, r.cfg_sel);
                K_BLOCK: begin
                    // The next row runs on the other port while this one holds req
                    fork
                        expect_stall(r);
                        issue(rows[i + 1], got_b, t_b, ok_b);
                    join
                    if (ok_b) begin
                        check_resp(rows[i + 1], got_b);
                    end
                    i++;
                end
                K_PAIR: begin
                    fork
                        issue(rows[i], got_a, t_a, ok_a);
                        issue(rows[i + 1], got_b, t_b, ok_b);
                    join
                    if (ok_a && ok_b) begin
                        // High-priority accept first, low one on the next cycle
                        assert (t_b - t_a == CLK_PERIOD) else begin
                            $display("FAILED accept gap: got 0x%0h expected 0x%0h",
                                     t_b - t_a, CLK_PERIOD);
                            errors++;
                        end
                        check_resp(rows[i], got_a);
                        check_resp(rows[i + 1], got_b);
                    end
                    i++;
                end
                default: begin
                    issue(r, got_a, t_a, ok_a);
                    if (ok_a) begin
                        check_resp(r, got_a);
                    end
                end
            endcase
            num_steps++;
            if (errors != err_before) begin
                failed_steps++;
            end
            $display("step %0d kind %0d port %0d key 0x%02h: %s", num_steps, r.kind, r.port,
                     r.key, (errors == err_before) ? "ok" : "mismatch");
            i++;
        end
        repeat (4) @(posedge clk);
        $display("%0d steps, %0d failed, %0d errors", num_steps, failed_steps, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/kv_pkg.sv
hw/kv_mux_cfg.sv
hw/kv_ctxt_fifo.sv
hw/kv_req_mux.sv
hw/kv_bank_demux.sv
hw/kv_bank.sv
hw/kv_fabric_top.sv
testbench/kv_fabric_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the key-value fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module kv_fabric_tb \
    -o sim_kv

./obj_dir/sim_kv | tee sim.log

grep -q "TEST RESULT: PASS" sim.log
